//--- logic/sync_timer_pkg.sv
`default_nettype none

package sync_timer_pkg;

    localparam int unsigned TIMER_WIDTH     = 64;
    localparam int unsigned CLK_NUMERATOR   = 10; // clock period 10/3 ns
    localparam int unsigned CLK_DENOMINATOR = 3;

    // whole ns per clock, the remainder goes through the accumulator
    localparam int unsigned FRAC_WIDTH = $clog2(CLK_DENOMINATOR) + 1;
    localparam logic [TIMER_WIDTH-1:0] STEP_INT =
        TIMER_WIDTH'(CLK_NUMERATOR / CLK_DENOMINATOR);
    localparam logic [FRAC_WIDTH-1:0] STEP_FRAC =
        FRAC_WIDTH'(CLK_NUMERATOR % CLK_DENOMINATOR);
    localparam logic [FRAC_WIDTH-1:0] FRAC_LIMIT = FRAC_WIDTH'(CLK_DENOMINATOR);
    localparam logic [TIMER_WIDTH-1:0] TIME_ONE   = TIMER_WIDTH'(1); // trim step

endpackage

`default_nettype wire

//--- logic/sync_frame_pkg.sv
`default_nettype none

package sync_frame_pkg;

    // frame: id, cmd, 8 time bytes, 4 offset bytes, multi-byte fields lsb first
    localparam int unsigned FRAME_LENGTH = 14;
    localparam int unsigned TIME_POS     = 2;
    localparam int unsigned OFFSET_POS   = 10;
    localparam int unsigned LAST_POS     = FRAME_LENGTH - 1;

    localparam logic [7:0]  NODE_ID     = 8'h01;
    localparam logic [31:0] LINK_OFFSET = 32'd1000; // transport delay in ns

    typedef enum logic [7:0] {
        CMD_SET    = 8'h10, // load the slave timer
        CMD_ADJUST = 8'h11  // trim by one ns toward the master
    } sync_cmd_t;

endpackage

`default_nettype wire

//--- logic/sync_timer.sv
`timescale 1ns/1ps
`default_nettype none

module sync_timer (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [sync_timer_pkg::TIMER_WIDTH-1:0] set_time,
    input  logic                                   set_valid,
    input  logic                                   adjust_sign,
    input  logic                                   adjust_valid,
    output logic                                   adjust_ready,
    output logic [sync_timer_pkg::TIMER_WIDTH-1:0] current_time
);

    logic [sync_timer_pkg::FRAC_WIDTH-1:0]  frac_acc;
    logic [sync_timer_pkg::FRAC_WIDTH-1:0]  frac_sum;
    logic [sync_timer_pkg::FRAC_WIDTH-1:0]  frac_next;
    logic                                   frac_carry;
    logic                                   adjust_take;
    logic [sync_timer_pkg::TIMER_WIDTH-1:0] step;

    // remainder accumulator, carries one extra ns when it wraps
    always_comb begin
        frac_sum   = frac_acc + sync_timer_pkg::STEP_FRAC;
        frac_carry = (frac_sum >= sync_timer_pkg::FRAC_LIMIT);
        if (frac_carry) begin
            frac_next = frac_sum - sync_timer_pkg::FRAC_LIMIT;
        end else begin
            frac_next = frac_sum;
        end
    end

    assign adjust_take = adjust_valid && adjust_ready;

    always_comb begin
        step = sync_timer_pkg::STEP_INT;
        if (frac_carry) begin
            step = step + sync_timer_pkg::TIME_ONE;
        end
        if (adjust_take) begin
            if (adjust_sign) begin
                step = step - sync_timer_pkg::TIME_ONE; // slow down
            end else begin
                step = step + sync_timer_pkg::TIME_ONE; // catch up
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            current_time <= '0;
            frac_acc     <= '0;
            adjust_ready <= 1'b1;
        end else begin
            adjust_ready <= !adjust_take; // one busy cycle per trim
            if (set_valid) begin
                current_time <= set_time;
                frac_acc     <= '0;
            end else begin
                current_time <= current_time + step;
                frac_acc     <= frac_next;
            end
        end
    end

    // load and trim come from the same owner and must not collide
    property p_set_adjust_exclusive;
        @(posedge clk) disable iff (reset)
            !(set_valid && adjust_valid);
    endproperty

    assert property (p_set_adjust_exclusive)
        else $error("sync_timer: set and adjust requested together");

endmodule

`default_nettype wire

//--- logic/sync_master.sv
`timescale 1ns/1ps
`default_nettype none

module sync_master (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   sync_start,
    input  logic                                   sync_override,
    output logic [sync_timer_pkg::TIMER_WIDTH-1:0] current_time,
    output logic [7:0]                             m_data,
    output logic                                   m_last,
    output logic                                   m_valid,
    input  logic                                   m_ready
);

    logic [sync_frame_pkg::FRAME_LENGTH-1:0][7:0] frame_data;
    logic [sync_frame_pkg::FRAME_LENGTH-1:0]      frame_last;
    sync_frame_pkg::sync_cmd_t                    frame_cmd;

    assign frame_cmd = sync_override ? sync_frame_pkg::CMD_SET : sync_frame_pkg::CMD_ADJUST;

    // entry 0 is the byte on the stream, a new start always reloads
    always_ff @(posedge clk) begin
        if (sync_start) begin
            frame_data[0] <= sync_frame_pkg::NODE_ID;
            frame_data[1] <= frame_cmd;
            frame_data[sync_frame_pkg::OFFSET_POS-1:sync_frame_pkg::TIME_POS] <= current_time;
            frame_data[sync_frame_pkg::LAST_POS:sync_frame_pkg::OFFSET_POS] <=
                sync_frame_pkg::LINK_OFFSET;
            frame_last <= {1'b1, {(sync_frame_pkg::FRAME_LENGTH-1){1'b0}}};
        end else if (m_valid && m_ready) begin
            frame_data <= frame_data >> 8;
            frame_last <= frame_last >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            m_valid <= 1'b0;
        end else if (sync_start) begin
            m_valid <= 1'b1;
        end else if (m_valid && m_ready) begin
            m_valid <= !m_last; // drop after the final byte
        end
    end

    assign m_data = frame_data[0];
    assign m_last = frame_last[0];

    // free-running reference, never loaded or trimmed
    sync_timer u_sync_timer (
        .clk          (clk),
        .reset        (reset),
        .set_time     ('0),
        .set_valid    (1'b0),
        .adjust_sign  (1'b0),
        .adjust_valid (1'b0),
        .adjust_ready (),
        .current_time (current_time)
    );

    // a stalled byte holds until taken, unless the frame restarts
    property p_stream_hold;
        @(posedge clk) disable iff (reset)
            m_valid && !m_ready && !sync_start |=> $stable(m_data) && $stable(m_last);
    endproperty

    assert property (p_stream_hold)
        else $error("sync_master: stream changed under back-pressure");

endmodule

`default_nettype wire

//--- logic/sync_slave.sv
`timescale 1ns/1ps
`default_nettype none

module sync_slave (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [7:0]                             s_data,
    input  logic                                   s_last,
    input  logic                                   s_valid,
    output logic                                   s_ready,
    output logic [sync_timer_pkg::TIMER_WIDTH-1:0] current_time,
    output logic                                   sync_event
);

    typedef enum logic [2:0] {
        RX_ID,
        RX_CMD,
        RX_TIME,
        RX_OFFSET,
        APPLY
    } rx_state_t;

    rx_state_t                                     state;
    logic [$clog2(sync_frame_pkg::FRAME_LENGTH)-1:0] byte_cnt;
    logic                                          s_take;

    sync_frame_pkg::sync_cmd_t                     rx_cmd;
    logic [sync_timer_pkg::TIMER_WIDTH-1:0]        rx_time;
    logic [31:0]                                   rx_offset;
    logic [31:0]                                   offset_next;
    logic [sync_timer_pkg::TIMER_WIDTH-1:0]        time_next;
    logic [sync_timer_pkg::TIMER_WIDTH-1:0]        target_next;
    logic [sync_timer_pkg::TIMER_WIDTH-1:0]        target;
    logic                                          apply_ok;
    logic                                          slave_ahead;
    logic                                          slave_behind;

    logic                                          set_valid;
    logic                                          adjust_valid;
    logic                                          adjust_ready;

    assign s_take = s_valid && s_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= RX_ID;
            byte_cnt <= '0;
        end else if (state == APPLY) begin
            state    <= RX_ID;
            byte_cnt <= '0;
        end else if (s_take) begin
            if (byte_cnt != sync_frame_pkg::LAST_POS) begin
                byte_cnt <= byte_cnt + 1'b1; // saturates on a restarted frame
            end
            if (s_last) begin
                state <= APPLY;
            end else begin
                case (state)
                    RX_ID:   state <= RX_CMD;
                    RX_CMD:  state <= RX_TIME;
                    RX_TIME: begin
                        if (byte_cnt == sync_frame_pkg::OFFSET_POS - 1) begin
                            state <= RX_OFFSET;
                        end
                    end
                    default: state <= RX_OFFSET; // wait for last
                endcase
            end
        end
    end

    // fields form one sliding window so the bytes before last always line up
    assign offset_next = {s_data, rx_offset[31:8]};
    assign time_next   = {rx_offset[7:0], rx_time[sync_timer_pkg::TIMER_WIDTH-1:8]};
    assign target_next = time_next +
        {{(sync_timer_pkg::TIMER_WIDTH-32){1'b0}}, offset_next};

    always_ff @(posedge clk) begin
        if (s_take) begin
            rx_cmd    <= sync_frame_pkg::sync_cmd_t'(rx_time[7:0]);
            rx_time   <= time_next;
            rx_offset <= offset_next;
            if (s_last) begin
                // rx_cmd holds the id byte at this point
                apply_ok     <= (byte_cnt == sync_frame_pkg::LAST_POS) &&
                                (rx_cmd == sync_frame_pkg::NODE_ID);
                target       <= target_next;
                slave_ahead  <= (current_time > target_next);
                slave_behind <= (current_time < target_next);
            end
        end
    end

    assign sync_event   = (state == APPLY) && apply_ok;
    assign set_valid    = sync_event && (rx_cmd == sync_frame_pkg::CMD_SET);
    assign adjust_valid = sync_event && (rx_cmd == sync_frame_pkg::CMD_ADJUST) &&
                          (slave_ahead || slave_behind);
    assign s_ready      = (state != APPLY) && adjust_ready;

    sync_timer u_sync_timer (
        .clk          (clk),
        .reset        (reset),
        .set_time     (target),
        .set_valid    (set_valid),
        .adjust_sign  (slave_ahead), // ahead means step back
        .adjust_valid (adjust_valid),
        .adjust_ready (adjust_ready),
        .current_time (current_time)
    );

    // a trim is only requested while the timer is free
    property p_adjust_when_ready;
        @(posedge clk) disable iff (reset)
            adjust_valid |-> adjust_ready;
    endproperty

    assert property (p_adjust_when_ready)
        else $error("sync_slave: adjust issued while timer busy");

endmodule

`default_nettype wire

//--- logic/sync_timer_link.sv
`timescale 1ns/1ps
`default_nettype none

module sync_timer_link (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   sync_start,
    input  logic                                   sync_override,
    output logic [sync_timer_pkg::TIMER_WIDTH-1:0] master_time,
    output logic [sync_timer_pkg::TIMER_WIDTH-1:0] slave_time,
    output logic                                   sync_event,
    output logic [7:0]                             link_data,
    output logic                                   link_last,
    output logic                                   link_valid,
    output logic                                   link_ready
);

    // master side, owns the reference time
    sync_master u_sync_master (
        .clk           (clk),
        .reset         (reset),
        .sync_start    (sync_start),
        .sync_override (sync_override),
        .current_time  (master_time),
        .m_data        (link_data),
        .m_last        (link_last),
        .m_valid       (link_valid),
        .m_ready       (link_ready)
    );

    // slave side follows the master over the byte stream
    sync_slave u_sync_slave (
        .clk          (clk),
        .reset        (reset),
        .s_data       (link_data),
        .s_last       (link_last),
        .s_valid      (link_valid),
        .s_ready      (link_ready),
        .current_time (slave_time),
        .sync_event   (sync_event)
    );

endmodule

`default_nettype wire

//--- verification/sync_timer_link_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sync_timer_link_tb;

    localparam int          HALF_PERIOD     = 20; // 40 ns clock
    localparam int          DRIVE_DELAY     = 2;
    localparam int          RESET_CYCLES    = 16;
    localparam int          FRAME_COUNT     = 26; // every sync_start issued
    localparam int          RANDOM_FRAMES   = FRAME_COUNT - 6;
    localparam int          WATCHDOG_CYCLES = FRAME_COUNT * 60 + 2000;
    localparam int          WAIT_LIMIT      = 100;
    localparam int unsigned RANDOM_SEED     = 32'h5896_4b0e;

    logic                                   clk;
    logic                                   reset;
    logic                                   sync_start;
    logic                                   sync_override;
    logic [sync_timer_pkg::TIMER_WIDTH-1:0] master_time;
    logic [sync_timer_pkg::TIMER_WIDTH-1:0] slave_time;
    logic                                   sync_event;
    logic [7:0]                             link_data;
    logic                                   link_last;
    logic                                   link_valid;
    logic                                   link_ready;

    // reference model state, advanced once per clock at the falling edge
    logic                                   model_on = 1'b0;
    longint unsigned                        master_n;
    longint unsigned                        slave_n;
    logic [63:0]                            slave_base;
    logic [63:0]                            slave_now;
    logic [63:0]                            sent_time;
    logic [7:0]                             sent_cmd;
    logic [7:0]                             pending_cmd;
    logic [63:0]                            pending_target;
    longint                                 pending_delta;
    int                                     frame_idx;
    logic                                   xfer;
    logic                                   last_now;
    logic                                   event_due;
    logic                                   adj_busy;
    logic                                   busy_next;
    logic                                   exp_valid;

    int                                     error_count = 0;
    int                                     event_count = 0;
    int                                     frames_expected;
    int                                     trims_up = 0;
    int                                     trims_down = 0;
    int unsigned                            seed_dummy;
    int unsigned                            gap;

    sync_timer_link u_sync_timer_link (
        .clk           (clk),
        .reset         (reset),
        .sync_start    (sync_start),
        .sync_override (sync_override),
        .master_time   (master_time),
        .slave_time    (slave_time),
        .sync_event    (sync_event),
        .link_data     (link_data),
        .link_last     (link_last),
        .link_valid    (link_valid),
        .link_ready    (link_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // load value plus floor(n * NUMERATOR / DENOMINATOR)
    function automatic logic [63:0] expected_time(input logic [63:0] load_value,
                                                  input longint unsigned ticks);
        return load_value + (ticks * sync_timer_pkg::CLK_NUMERATOR) /
            sync_timer_pkg::CLK_DENOMINATOR;
    endfunction

    // id, cmd, time lsb first, offset lsb first
    function automatic logic [7:0] frame_byte(input int idx, input logic [63:0] t,
                                              input logic [7:0] cmd);
        logic [31:0] ofs;
        ofs = sync_frame_pkg::LINK_OFFSET;
        if (idx == 0) begin
            return sync_frame_pkg::NODE_ID;
        end else if (idx == 1) begin
            return cmd;
        end else if (idx < 10) begin
            return t[8*(idx-2) +: 8];
        end
        return ofs[8*(idx-10) +: 8];
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    always @(negedge clk) begin
        if (model_on) begin
            check_value(master_time, expected_time(64'd0, master_n), "master_time");
            check_value(slave_time, expected_time(slave_base, slave_n), "slave_time");
            check_value(sync_event, event_due, "sync_event");
            check_value(link_valid, exp_valid, "link_valid");
            check_value(link_ready, !event_due && !adj_busy, "link_ready");
        end
        xfer = link_valid && link_ready;
        if (model_on && xfer) begin
            check_value(link_data, frame_byte(frame_idx, sent_time, sent_cmd), "link_data");
            check_value(link_last, frame_idx == sync_frame_pkg::LAST_POS, "link_last");
        end
        if (reset) begin
            master_n   = 0;
            slave_n    = 0;
            slave_base = '0;
            frame_idx  = 0;
            event_due  = 1'b0;
            adj_busy   = 1'b0;
            exp_valid  = 1'b0;
            model_on   = 1'b1;
        end else if (model_on) begin
            slave_now = expected_time(slave_base, slave_n);
            last_now  = 1'b0;
            if (xfer) begin
                if (frame_idx == sync_frame_pkg::LAST_POS) begin
                    last_now       = 1'b1;
                    pending_cmd    = sent_cmd;
                    pending_target = sent_time + sync_frame_pkg::LINK_OFFSET;
                    if (slave_now > pending_target) begin
                        pending_delta = -1; // slave ahead
                    end else if (slave_now < pending_target) begin
                        pending_delta = 1;
                    end else begin
                        pending_delta = 0;
                    end
                    exp_valid = 1'b0;
                end
                frame_idx++;
            end
            if (sync_start) begin
                sent_time = expected_time(64'd0, master_n); // captured on the next edge
                sent_cmd  = sync_override ? sync_frame_pkg::CMD_SET : sync_frame_pkg::CMD_ADJUST;
                frame_idx = 0;
                exp_valid = 1'b1;
            end
            busy_next = 1'b0;
            master_n++;
            if (event_due && pending_cmd == sync_frame_pkg::CMD_SET) begin
                slave_base = pending_target;
                slave_n    = 0;
            end else begin
                slave_n++;
                if (event_due) begin
                    slave_base = slave_base + 64'(pending_delta);
                    busy_next  = (pending_delta != 0);
                    if (pending_delta > 0) trims_up++;
                    if (pending_delta < 0) trims_down++;
                end
            end
            if (event_due) begin
                event_count++;
            end
            event_due = last_now;
            adj_busy  = busy_next;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic send_start(input logic override);
        sync_start    = 1'b1;
        sync_override = override;
        next_cycle();
        sync_start    = 1'b0;
    endtask

    task automatic wait_events(input int target);
        int waited;
        waited = 0;
        while (event_count < target && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (event_count < target) begin
            error_count++;
            $display("Error: sync_event did not arrive within %0d clocks at %0t ns",
                     WAIT_LIMIT, $time);
        end
    endtask

    task automatic wait_byte_index(input int target);
        int waited;
        waited = 0;
        while (frame_idx < target && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (frame_idx < target) begin
            error_count++;
            $display("Error: link stalled before byte %0d at %0t ns", target, $time);
        end
    endtask

    task automatic run_frame(input logic override);
        send_start(override);
        frames_expected++;
        wait_events(frames_expected);
    endtask

    initial begin
        seed_dummy      = $urandom(RANDOM_SEED);
        reset           = 1'b1;
        sync_start      = 1'b0;
        sync_override   = 1'b0;
        frames_expected = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        repeat (30) next_cycle(); // free running only
        run_frame(1'b0);          // timers still equal
        run_frame(1'b1);
        repeat (RANDOM_FRAMES) begin
            gap = $urandom % 24;
            repeat (gap) next_cycle();
            run_frame(($urandom % 3) == 0);
        end

        // restart in the middle of a frame
        repeat (5) next_cycle();
        send_start(1'b0);
        wait_byte_index(5);
        send_start(1'b1);
        frames_expected++;
        wait_events(frames_expected);

        // next start lands on the last byte, slave back-pressures the new frame
        repeat (5) next_cycle();
        send_start(1'b0);
        wait_byte_index(13);
        send_start(1'b0);
        frames_expected += 2;
        wait_events(frames_expected);

        repeat (20) next_cycle();
        check_value(event_count, frames_expected, "sync_event count");
        $display("errors %0d, frames %0d, sync events %0d, trims up %0d down %0d",
                 error_count, frames_expected, event_count, trims_up, trims_down);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Error: run timed out after %0d clocks without finishing", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sync_timer_link.f
logic/sync_timer_pkg.sv
logic/sync_frame_pkg.sv
logic/sync_timer.sv
logic/sync_master.sv
logic/sync_slave.sv
logic/sync_timer_link.sv
verification/sync_timer_link_tb.sv
